// File: hw/bus_pkg.sv
package bus_pkg;

  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_start = 2'b01,
    st_pre   = 2'b10,
    st_post  = 2'b11
  } bus_state_t;

  localparam int master_cpu = 0; // grant bit positions
  localparam int master_vga = 1;

  localparam logic [3:0] cs_none       = 4'd0;
  localparam logic [3:0] cs_vectors    = 4'd1;
  localparam logic [3:0] cs_rom        = 4'd2;
  localparam logic [3:0] cs_ram        = 4'd3;
  localparam logic [3:0] cs_io         = 4'd4;
  localparam logic [3:0] cs_led_matrix = 4'd5;
  localparam logic [3:0] cs_ssram      = 4'd6;

  localparam logic [1:0] map_ram_low = 2'b11; // all other map values use the default layout

  localparam logic [31:0] ram_low_start   = 32'h0000_0000;
  localparam logic [31:0] ram_low_end     = 32'h0000_3fff;
  localparam logic [31:0] ssram_low_start = 32'h0000_4000; // ssram shrinks when ram sits low
  localparam logic [31:0] ssram_start     = 32'h0000_0000;
  localparam logic [31:0] ssram_end       = 32'h000f_ffff;
  localparam logic [31:0] led_start       = 32'h0080_0000;
  localparam logic [31:0] led_end         = 32'h0080_07ff;
  localparam logic [31:0] io_start        = 32'h0080_0800;
  localparam logic [31:0] io_end          = 32'h0080_0fff;
  localparam logic [31:0] ram_high_start  = 32'hffff_8000;
  localparam logic [31:0] ram_high_end    = 32'hffff_bfff;
  localparam logic [31:0] rom_start       = 32'hffff_0000;
  localparam logic [31:0] rom_end         = 32'hffff_ffbf;
  localparam logic [31:0] vec_start       = 32'hffff_ffc0;
  localparam logic [31:0] vec_end         = 32'hffff_ffff;

  localparam logic [3:0] ram_wait_states = 4'd0;
  localparam logic [3:0] io_wait_states  = 4'd2;

  localparam int ram_depth = 256; // words, address bits 9:2
  localparam int io_count  = 4;   // registers, address bits 3:2

endpackage

// File: hw/address_decoder.sv
`timescale 1ns/1ps

module address_decoder import bus_pkg::*; (
  input  logic [31:0] address,
  input  logic [1:0]  map,
  output logic [3:0]  cs_code
);

  function automatic logic in_range(
    input logic [31:0] addr,
    input logic [31:0] first,
    input logic [31:0] last
  );
    return (addr >= first) && (addr <= last);
  endfunction

  // first match wins, ram is checked before the rom window it overlaps
  always_comb begin
    if (map == map_ram_low) begin
      if (in_range(address, ram_low_start, ram_low_end))
        cs_code = cs_ram;
      else if (in_range(address, ssram_low_start, ssram_end))
        cs_code = cs_ssram;
      else if (in_range(address, led_start, led_end))
        cs_code = cs_led_matrix;
      else if (in_range(address, io_start, io_end))
        cs_code = cs_io;
      else if (in_range(address, rom_start, rom_end))
        cs_code = cs_rom;
      else if (in_range(address, vec_start, vec_end))
        cs_code = cs_vectors;
      else
        cs_code = cs_none;
    end else begin
      if (in_range(address, ssram_start, ssram_end))
        cs_code = cs_ssram;
      else if (in_range(address, led_start, led_end))
        cs_code = cs_led_matrix;
      else if (in_range(address, io_start, io_end))
        cs_code = cs_io;
      else if (in_range(address, ram_high_start, ram_high_end))
        cs_code = cs_ram; // inside the rom range
      else if (in_range(address, rom_start, rom_end))
        cs_code = cs_rom;
      else if (in_range(address, vec_start, vec_end))
        cs_code = cs_vectors;
      else
        cs_code = cs_none;
    end
  end

endmodule

// File: hw/bus_controller.sv
`timescale 1ns/1ps

module bus_controller import bus_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] cpu_address,
  input  logic [31:0] vga_address,
  input  logic        cpu_read,
  input  logic        vga_read,
  input  logic        cpu_write,
  input  logic [3:0]  cpu_be,
  input  logic [31:0] cpu_writedata,
  input  logic [3:0]  cs_code,
  output logic [31:0] address,
  output logic        read,
  output logic        write,
  output logic        start,
  output logic        cpu_wait,
  output logic        vga_wait,
  output logic [3:0]  be,
  output logic [31:0] writedata,
  output logic [3:0]  chipselect
);

  bus_state_t  state, state_next;
  logic [1:0]  grant, grant_next; // one-hot
  logic [3:0]  delay, delay_next;
  logic [3:0]  wait_count;
  logic        cpu_req;
  logic        granted_req;

  assign cpu_req = cpu_read | cpu_write;

  // request of whichever master holds the bus
  assign granted_req = (grant[master_cpu] & cpu_req) |
                       (grant[master_vga] & vga_read);

  // per-region wait states, others run at zero
  always_comb begin
    case (cs_code)
      cs_ram:  wait_count = ram_wait_states;
      cs_io:   wait_count = io_wait_states;
      default: wait_count = 4'd0;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      grant <= 2'b00;
      delay <= 4'd0;
    end else begin
      state <= state_next;
      grant <= grant_next;
      delay <= delay_next;
    end
  end

  always_comb begin
    state_next = state;
    grant_next = grant;
    delay_next = delay;
    case (state)
      st_idle: begin
        if (cpu_req) begin // cpu has priority
          state_next = st_start;
          grant_next[master_cpu] = 1'b1;
        end else if (vga_read) begin
          state_next = st_start;
          grant_next[master_vga] = 1'b1;
        end
      end
      st_start: begin
        if (granted_req) begin
          state_next = st_pre;
          delay_next = wait_count;
        end else begin
          state_next = st_idle;
          grant_next = 2'b00;
        end
      end
      st_pre: begin
        if (!granted_req) begin // master withdrew, abort
          state_next = st_idle;
          grant_next = 2'b00;
          delay_next = 4'd0;
        end else if (delay == 4'd0) begin
          state_next = st_post;
        end else begin
          delay_next = delay - 4'd1;
        end
      end
      st_post: begin
        if (!granted_req) begin
          state_next = st_idle;
          grant_next = 2'b00;
        end
      end
      default: begin
        state_next = st_idle;
        grant_next = 2'b00;
      end
    endcase
  end

  assign address   = grant[master_cpu] ? cpu_address :
                     grant[master_vga] ? vga_address : 32'h0;
  assign read      = grant[master_cpu] ? cpu_read :
                     grant[master_vga] ? vga_read : 1'b0;
  assign write     = grant[master_cpu] ? cpu_write : 1'b0; // vga never writes
  assign be        = grant[master_cpu] ? cpu_be :
                     grant[master_vga] ? 4'hf : 4'h0;
  assign writedata = grant[master_cpu] ? cpu_writedata : 32'h0;

  assign chipselect = (state == st_idle) ? cs_none : cs_code;
  assign start      = (state == st_start);

  assign cpu_wait = !(grant[master_cpu] && state == st_post);
  assign vga_wait = !(grant[master_vga] && state == st_post);

endmodule

// File: hw/slave_bank.sv
`timescale 1ns/1ps

module slave_bank import bus_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [3:0]  chipselect,
  input  logic [31:0] address,
  input  logic        read,
  input  logic        write,
  input  logic [3:0]  be,
  input  logic [31:0] writedata,
  output logic [31:0] readdata,
  output logic [7:0]  leds
);

  localparam int ram_bits = $clog2(ram_depth);
  localparam int io_bits  = $clog2(io_count);

  logic [31:0]         ram [ram_depth];
  logic [31:0]         io_regs [io_count];
  logic [ram_bits-1:0] ram_index;
  logic [io_bits-1:0]  io_index;
  logic                ram_we;
  logic                io_we;

  // word index, upper bits ignored so the ram aliases
  assign ram_index = address[ram_bits+1:2];
  assign io_index  = address[io_bits+1:2];

  assign ram_we = write && (chipselect == cs_ram);
  assign io_we  = write && (chipselect == cs_io);

  always_ff @(posedge clock) begin
    if (ram_we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i])
          ram[ram_index][8*i +: 8] <= writedata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < io_count; r++)
        io_regs[r] <= 32'h0;
    end else if (io_we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i])
          io_regs[io_index][8*i +: 8] <= writedata[8*i +: 8];
      end
    end
  end

  always_comb begin
    readdata = 32'h0;
    if (read) begin
      case (chipselect)
        cs_ram:  readdata = ram[ram_index];
        cs_io:   readdata = io_regs[io_index];
        default: readdata = 32'h0; // no slave behind the other regions
      endcase
    end
  end

  assign leds = io_regs[0][7:0];

endmodule

// File: hw/bus_top.sv
`timescale 1ns/1ps

module bus_top (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] cpu_address,
  input  logic        cpu_read,
  input  logic        cpu_write,
  input  logic [3:0]  cpu_be,
  input  logic [31:0] cpu_writedata,
  input  logic [31:0] vga_address,
  input  logic        vga_read,
  input  logic [1:0]  map,
  output logic        cpu_wait,
  output logic        vga_wait,
  output logic [31:0] readdata,
  output logic [7:0]  leds
);

  logic [31:0] address;
  logic        read;
  logic        write;
  logic [3:0]  be;
  logic [31:0] writedata;
  logic [3:0]  cs_code;
  logic [3:0]  chipselect;

  bus_controller controller (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_address   (cpu_address),
    .vga_address   (vga_address),
    .cpu_read      (cpu_read),
    .vga_read      (vga_read),
    .cpu_write     (cpu_write),
    .cpu_be        (cpu_be),
    .cpu_writedata (cpu_writedata),
    .cs_code       (cs_code),
    .address       (address),
    .read          (read),
    .write         (write),
    .start         (), // no slave here needs the start pulse
    .cpu_wait      (cpu_wait),
    .vga_wait      (vga_wait),
    .be            (be),
    .writedata     (writedata),
    .chipselect    (chipselect)
  );

  address_decoder decoder (
    .address (address),
    .map     (map),
    .cs_code (cs_code)
  );

  slave_bank slaves (
    .clock      (clock),
    .reset_n    (reset_n),
    .chipselect (chipselect),
    .address    (address),
    .read       (read),
    .write      (write),
    .be         (be),
    .writedata  (writedata),
    .readdata   (readdata),
    .leds       (leds)
  );

endmodule

// File: verification/bus_checker.sv
`timescale 1ns/1ps

module bus_checker import bus_pkg::*; (
  input logic       clock,
  input logic       reset_n,
  input bus_state_t state,
  input logic [1:0] grant,
  input logic       start,
  input logic [3:0] chipselect,
  input logic       cpu_wait,
  input logic       vga_wait
);

  grant_one_hot: assert property (@(posedge clock) disable iff (!reset_n)
    !(grant[master_cpu] && grant[master_vga]))
    else $error("both masters granted");

  // start is one cycle, then the transfer runs or aborts
  start_pulse: assert property (@(posedge clock) disable iff (!reset_n)
    start |=> !start && (state == st_pre || state == st_idle))
    else $error("start pulse malformed");

  // idle bus has no owner and no select
  idle_no_select: assert property (@(posedge clock) disable iff (!reset_n)
    (state == st_idle) |-> (chipselect == cs_none) && (grant == 2'b00))
    else $error("chipselect or grant active in st_idle");

  one_wait_low: assert property (@(posedge clock) disable iff (!reset_n)
    cpu_wait || vga_wait)
    else $error("both wait outputs low");

endmodule

bind bus_controller bus_checker protocol_check (
  .clock      (clock),
  .reset_n    (reset_n),
  .state      (state),
  .grant      (grant),
  .start      (start),
  .chipselect (chipselect),
  .cpu_wait   (cpu_wait),
  .vga_wait   (vga_wait)
);

// File: verification/bus_tb.sv
`timescale 1ns/1ps

module bus_tb import bus_pkg::*; ();

  localparam int timeout_cycles = 40;

  logic        clock = 1'b0;
  logic        reset_n;
  logic [31:0] cpu_address, cpu_writedata, vga_address;
  logic        cpu_read, cpu_write, vga_read;
  logic [3:0]  cpu_be;
  logic [1:0]  map;
  logic        cpu_wait, vga_wait;
  logic [31:0] readdata;
  logic [7:0]  leds;

  logic [31:0] lfsr = 32'd92797;
  logic [31:0] shadow_ram [ram_depth];
  logic [31:0] shadow_io [io_count];
  logic [31:0] filled [$]; // ram addresses the cpu has written
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_start_errors = 0;

  bus_top uut (.*);

  always #5 clock = ~clock;

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value = 32'h0;
    logic        fb;
    for (int i = 0; i < n; i++) begin
      fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
      lfsr  = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [3:0] expected_cs(input logic [31:0] a, input logic [1:0] m);
    if (a >= io_start && a <= io_end)
      return cs_io;
    if (a >= led_start && a <= led_end)
      return cs_led_matrix;
    if (a >= vec_start)
      return cs_vectors;
    if (m == map_ram_low) begin
      if (a <= ram_low_end)
        return cs_ram;
      if (a <= ssram_end)
        return cs_ssram;
    end else begin
      if (a <= ssram_end)
        return cs_ssram;
      if (a >= ram_high_start && a <= ram_high_end)
        return cs_ram; // carved out of the rom window
    end
    if (a >= rom_start)
      return cs_rom;
    return cs_none;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] a);
    case (expected_cs(a, map))
      cs_ram:  return shadow_ram[a[9:2]];
      cs_io:   return shadow_io[a[3:2]];
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] be_in);
    logic [31:0] result = old;
    for (int i = 0; i < 4; i++)
      if (be_in[i])
        result[8*i +: 8] = data[8*i +: 8];
    return result;
  endfunction

  task automatic compare(input string what, input logic [31:0] addr,
                         input logic [31:0] got, input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %s at %h: got %h expected %h", what, addr, got, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout: %s did not go low", what);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic cpu_access(input logic wr, input logic [31:0] addr, input logic [3:0] be_in,
                            input logic [31:0] data, output logic [31:0] rdata);
    logic [3:0] cs;
    int         cycles = 0;
    int         latency;
    cs = expected_cs(addr, map);
    latency = 3 + ((cs == cs_io) ? int'(io_wait_states) :
                   (cs == cs_ram) ? int'(ram_wait_states) : 0);
    @(negedge clock);
    cpu_address   = addr;
    cpu_be        = be_in;
    cpu_writedata = data;
    cpu_write     = wr;
    cpu_read      = !wr;
    while (cpu_wait && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
    end
    rdata = readdata;
    if (cpu_wait)
      report_timeout("cpu_wait");
    else
      compare("cpu_wait latency", addr, cycles, latency);
    cpu_read  = 1'b0;
    cpu_write = 1'b0;
    if (wr && cs == cs_ram)
      shadow_ram[addr[9:2]] = merge(shadow_ram[addr[9:2]], data, be_in);
    else if (wr && cs == cs_io)
      shadow_io[addr[3:2]] = merge(shadow_io[addr[3:2]], data, be_in);
  endtask

  task automatic vga_fetch(input logic [31:0] addr, output logic [31:0] rdata);
    int cycles = 0;
    @(negedge clock);
    vga_address = addr;
    vga_read    = 1'b1;
    while (vga_wait && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
    end
    rdata = readdata;
    if (vga_wait)
      report_timeout("vga_wait");
    vga_read = 1'b0;
  endtask

  // cpu write and vga read of the same word in one cycle
  task automatic race(input logic [31:0] addr, input logic [31:0] data);
    int cycles = 0;
    @(negedge clock);
    cpu_address   = addr;
    cpu_be        = 4'hf;
    cpu_writedata = data;
    cpu_write     = 1'b1;
    vga_address   = addr;
    vga_read      = 1'b1;
    while (cpu_wait && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
      compare("vga_wait", addr, {31'h0, vga_wait}, 32'h1);
    end
    if (cpu_wait)
      report_timeout("cpu_wait");
    cpu_write = 1'b0;
    shadow_ram[addr[9:2]] = data;
    cycles = 0;
    while (vga_wait && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
    end
    if (vga_wait)
      report_timeout("vga_wait");
    compare("vga readdata", addr, readdata, shadow_ram[addr[9:2]]);
    vga_read = 1'b0;
  endtask

  // access with no slave behind it, then check the aliased ram word
  task automatic region_check(input logic [31:0] a);
    logic [31:0] ram_addr;
    logic [31:0] rdata;
    ram_addr = {22'h0, a[9:2], 2'b00};
    map = map_ram_low;
    cpu_access(1'b1, ram_addr, 4'hf, random_bits(32), rdata);
    map = 2'b00;
    cpu_access(1'b1, a, 4'hf, random_bits(32), rdata);
    cpu_access(1'b0, a, 4'hf, 32'h0, rdata);
    compare("readdata", a, rdata, 32'h0);
    map = map_ram_low;
    cpu_access(1'b0, ram_addr, 4'hf, 32'h0, rdata);
    compare("readdata", ram_addr, rdata, shadow_ram[a[9:2]]);
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] rdata;
    reset_n       = 1'b0;
    cpu_address   = 32'h0;
    cpu_writedata = 32'h0;
    cpu_be        = 4'h0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    vga_address   = 32'h0;
    vga_read      = 1'b0;
    map           = map_ram_low;
    for (int r = 0; r < io_count; r++)
      shadow_io[r] = 32'h0;
    repeat (16) @(negedge clock);
    reset_n = 1'b1;

    for (int m = 0; m < 2; m++) begin
      map = (m == 0) ? map_ram_low : 2'b00;
      filled.delete();
      for (int i = 0; i < 8; i++) begin
        addr = ((m == 0) ? ram_low_start : ram_high_start) | (random_bits(8) << 2);
        cpu_access(1'b1, addr, 4'hf, random_bits(32), rdata); // whole word first
        cpu_access(1'b1, addr, 4'(random_bits(4)), random_bits(32), rdata);
        filled.push_back(addr);
      end
      foreach (filled[i]) begin
        cpu_access(1'b0, filled[i], 4'hf, 32'h0, rdata);
        compare("readdata", filled[i], rdata, expected_read(filled[i]));
      end
      finish_test((m == 0) ? "ram map 3" : "ram map 0");
    end

    for (int i = 0; i < 8; i++) begin
      addr = io_start | (random_bits(2) << 2);
      cpu_access(1'b1, addr, 4'(random_bits(4)), random_bits(32), rdata);
      compare("leds", addr, {24'h0, leds}, {24'h0, shadow_io[0][7:0]});
    end
    for (int r = 0; r < io_count; r++) begin
      addr = io_start | (r << 2);
      cpu_access(1'b0, addr, 4'hf, 32'h0, rdata);
      compare("readdata", addr, rdata, shadow_io[r]);
    end
    finish_test("io registers");

    for (int i = 0; i < 6; i++) begin
      addr = filled[random_bits(3)];
      vga_fetch(addr, rdata);
      compare("vga readdata", addr, rdata, expected_read(addr));
    end
    finish_test("vga reads");

    race(filled[0], random_bits(32));
    finish_test("arbitration");

    cpu_access(1'b0, filled[1], 4'hf, 32'h0, rdata); // latency is checked per access
    cpu_access(1'b0, io_start, 4'hf, 32'h0, rdata);
    finish_test("latency");

    region_check(32'h0100_0040); // unmapped
    region_check(32'h0000_1080); // ssram in the default layout
    region_check(32'hffff_0100); // rom
    finish_test("unbacked regions");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: flist.f
hw/bus_pkg.sv
hw/address_decoder.sv
hw/bus_controller.sv
hw/slave_bank.sv
hw/bus_top.sv
verification/bus_checker.sv
verification/bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the bus testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module bus_tb \
  -f flist.f \
  -o bus_sim

./obj_dir/bus_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1
